//--- include/icache_settings.svh
// **************************************************
// Geometry of the two-way instruction cache, shared by
// the package and every RTL module that sizes arrays
// **************************************************

`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Byte address width of the fetch and refill ports
`define ICACHE_ADDR_W 32

// Sets per way, one word per line
`define ICACHE_SETS 64

// log2 of the set count, index sits above the byte offset
`define ICACHE_INDEX_W 6

// Age counters saturate here
`define ICACHE_AGE_MAX 7

`endif

//--- hdl/icache_pkg.sv
// **************************************************
// Types for the instruction cache, referenced by
// scoped names from the RTL and the bench
// **************************************************

`include "icache_settings.svh"

package icache_pkg;

    localparam int ADDR_W  = `ICACHE_ADDR_W;
    localparam int WORD_W  = 32;
    localparam int INDEX_W = `ICACHE_INDEX_W;
    // Tag entry is everything above index and byte offset
    localparam int TAG_W   = ADDR_W - INDEX_W - 2;
    localparam int AGE_W   = $clog2(`ICACHE_AGE_MAX + 1);

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [AGE_W-1:0]   age_t;

    typedef enum logic {WAY0, WAY1} way_t;

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, RESPOND} ctrl_state_t;

endpackage

//--- hdl/icache_way_ram.sv
// **************************************************
// One array of a cache way, used for both tags and words
// Synchronous write, read data one edge after the index
// **************************************************

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_way_ram #(
    parameter type payload_t = icache_pkg::word_t,
    parameter int  SETS      = `ICACHE_SETS
) (
    input  logic               clk,
    input  logic               i_we,
    input  icache_pkg::index_t i_index,
    input  payload_t           i_wdata,
    output payload_t           o_rdata
);

    payload_t mem [SETS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_index] <= i_wdata;
        end
        // Old contents come out on a write cycle
        o_rdata <= mem[i_index];
    end

endmodule

//--- hdl/icache_set_state.sv
// **************************************************
// Valid bits and age counters of both ways per set
// Victim of the indexed set is given combinationally
// **************************************************

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_set_state (
    input  logic               clk,
    input  logic               rst,
    input  icache_pkg::index_t i_index,
    input  logic               i_lookup,
    input  logic               i_touch,
    input  logic               i_fill,
    input  icache_pkg::way_t   i_way,
    output logic               o_valid0,
    output logic               o_valid1,
    output icache_pkg::way_t   o_victim
);

    logic [`ICACHE_SETS-1:0] valid0_q;
    logic [`ICACHE_SETS-1:0] valid1_q;
    icache_pkg::age_t        age0_q [`ICACHE_SETS];
    icache_pkg::age_t        age1_q [`ICACHE_SETS];

    function automatic icache_pkg::age_t age_inc(input icache_pkg::age_t age);
        if (age == icache_pkg::age_t'(`ICACHE_AGE_MAX)) begin
            return age;
        end
        return age + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid0_q <= '0;
            valid1_q <= '0;
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                age0_q[s] <= '0;
                age1_q[s] <= '0;
            end
        end else begin
            // Every access ages both ways of its set
            if (i_lookup) begin
                age0_q[i_index] <= age_inc(age0_q[i_index]);
                age1_q[i_index] <= age_inc(age1_q[i_index]);
            end
            // Touch or fill wins over the increment
            if (i_touch || i_fill) begin
                if (i_way == icache_pkg::WAY0) begin
                    age0_q[i_index] <= '0;
                end else begin
                    age1_q[i_index] <= '0;
                end
            end
            if (i_fill) begin
                if (i_way == icache_pkg::WAY0) begin
                    valid0_q[i_index] <= 1'b1;
                end else begin
                    valid1_q[i_index] <= 1'b1;
                end
            end
        end
    end

    assign o_valid0 = valid0_q[i_index];
    assign o_valid1 = valid1_q[i_index];

    // Empty way first, then the older one, way 0 on a tie
    always_comb begin
        if (!o_valid0) begin
            o_victim = icache_pkg::WAY0;
        end else if (!o_valid1) begin
            o_victim = icache_pkg::WAY1;
        end else if (age1_q[i_index] > age0_q[i_index]) begin
            o_victim = icache_pkg::WAY1;
        end else begin
            o_victim = icache_pkg::WAY0;
        end
    end

endmodule

//--- hdl/icache_ctrl.sv
// **************************************************
// Lookup and refill FSM of the instruction cache
// Drives RAM index and write enables, set state strobes
// **************************************************

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_req,
    input  icache_pkg::addr_t   i_addr,
    output logic                o_busy,
    output logic                o_valid,
    output icache_pkg::word_t   o_data,
    output logic                o_mem_req,
    output icache_pkg::addr_t   o_mem_addr,
    input  logic                i_mem_ack,
    input  icache_pkg::word_t   i_mem_data,
    output icache_pkg::index_t  o_ram_index,
    output icache_pkg::tag_t    o_tag_wdata,
    output icache_pkg::word_t   o_data_wdata,
    output logic                o_we0,
    output logic                o_we1,
    input  icache_pkg::tag_t    i_tag0,
    input  icache_pkg::tag_t    i_tag1,
    input  icache_pkg::word_t   i_word0,
    input  icache_pkg::word_t   i_word1,
    output logic                o_lookup,
    output logic                o_touch,
    output logic                o_fill,
    output icache_pkg::way_t    o_way,
    input  logic                i_valid0,
    input  logic                i_valid1,
    input  icache_pkg::way_t    i_victim
);

    icache_pkg::ctrl_state_t state_q;
    icache_pkg::addr_t       addr_q;
    icache_pkg::word_t       data_q;
    icache_pkg::tag_t        tag_q;
    logic                    valid_q;
    logic                    mem_req_q;
    logic                    accept;
    logic                    hit0;
    logic                    hit1;
    logic                    hit;
    logic                    ack_ok;

    // **************************************************
    // Lookup and refill decode
    // **************************************************

    assign accept = (state_q == icache_pkg::IDLE) && i_req && !o_busy;
    assign tag_q  = addr_q[`ICACHE_ADDR_W-1 -: icache_pkg::TAG_W];

    // Index comes straight from the fetch address while idle
    assign o_ram_index = (state_q == icache_pkg::IDLE) ?
                         i_addr[`ICACHE_INDEX_W+1:2] : addr_q[`ICACHE_INDEX_W+1:2];

    assign hit0   = (state_q == icache_pkg::LOOKUP) && i_valid0 && (i_tag0 == tag_q);
    assign hit1   = (state_q == icache_pkg::LOOKUP) && i_valid1 && (i_tag1 == tag_q);
    assign hit    = hit0 || hit1;
    assign ack_ok = (state_q == icache_pkg::REFILL) && mem_req_q && i_mem_ack;

    assign o_lookup = accept;
    assign o_touch  = hit;
    assign o_fill   = ack_ok;
    assign o_way    = (state_q == icache_pkg::LOOKUP) ?
                      (hit1 ? icache_pkg::WAY1 : icache_pkg::WAY0) : i_victim;

    // Refill lands in the victim way
    assign o_we0        = ack_ok && (i_victim == icache_pkg::WAY0);
    assign o_we1        = ack_ok && (i_victim == icache_pkg::WAY1);
    assign o_tag_wdata  = tag_q;
    assign o_data_wdata = i_mem_data;

    // **************************************************
    // State and output registers
    // **************************************************

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q   <= icache_pkg::IDLE;
            valid_q   <= 1'b0;
            mem_req_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                icache_pkg::IDLE: begin
                    if (accept) begin
                        state_q <= icache_pkg::LOOKUP;
                    end
                end
                icache_pkg::LOOKUP: begin
                    state_q <= hit ? icache_pkg::RESPOND : icache_pkg::REFILL;
                end
                icache_pkg::REFILL: begin
                    // Request held until the ack edge
                    if (!mem_req_q) begin
                        mem_req_q <= 1'b1;
                    end else if (i_mem_ack) begin
                        mem_req_q <= 1'b0;
                        state_q   <= icache_pkg::RESPOND;
                    end
                end
                icache_pkg::RESPOND: begin
                    valid_q <= 1'b1;
                    state_q <= icache_pkg::IDLE;
                end
                default: begin
                    state_q <= icache_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_addr;
        end
        if (hit) begin
            data_q <= hit1 ? i_word1 : i_word0;
        end else if (ack_ok) begin
            data_q <= i_mem_data;
        end
    end

    // Busy covers the response cycle too
    assign o_busy     = (state_q != icache_pkg::IDLE) || valid_q;
    assign o_valid    = valid_q;
    assign o_data     = data_q;
    assign o_mem_req  = mem_req_q;
    assign o_mem_addr = addr_q;

endmodule

//--- hdl/icache_top.sv
// **************************************************
// Two-way instruction cache, fetch port and refill port
// Controller, set state and the tag and data arrays
// **************************************************

`timescale 1ns/1ps

module icache_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_req,
    input  icache_pkg::addr_t i_addr,
    output logic              o_busy,
    output logic              o_valid,
    output icache_pkg::word_t o_data,
    output logic              o_mem_req,
    output icache_pkg::addr_t o_mem_addr,
    input  logic              i_mem_ack,
    input  icache_pkg::word_t i_mem_data
);

    icache_pkg::index_t ram_index;
    icache_pkg::tag_t   tag_wdata;
    icache_pkg::word_t  data_wdata;
    icache_pkg::tag_t   tag0;
    icache_pkg::tag_t   tag1;
    icache_pkg::word_t  word0;
    icache_pkg::word_t  word1;
    icache_pkg::way_t   way;
    icache_pkg::way_t   victim;
    logic               we0;
    logic               we1;
    logic               lookup;
    logic               touch;
    logic               fill;
    logic               valid0;
    logic               valid1;

    icache_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .i_req        (i_req),
        .i_addr       (i_addr),
        .o_busy       (o_busy),
        .o_valid      (o_valid),
        .o_data       (o_data),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_ack    (i_mem_ack),
        .i_mem_data   (i_mem_data),
        .o_ram_index  (ram_index),
        .o_tag_wdata  (tag_wdata),
        .o_data_wdata (data_wdata),
        .o_we0        (we0),
        .o_we1        (we1),
        .i_tag0       (tag0),
        .i_tag1       (tag1),
        .i_word0      (word0),
        .i_word1      (word1),
        .o_lookup     (lookup),
        .o_touch      (touch),
        .o_fill       (fill),
        .o_way        (way),
        .i_valid0     (valid0),
        .i_valid1     (valid1),
        .i_victim     (victim)
    );

    icache_set_state set_state_i (
        .clk      (clk),
        .rst      (rst),
        .i_index  (ram_index),
        .i_lookup (lookup),
        .i_touch  (touch),
        .i_fill   (fill),
        .i_way    (way),
        .o_valid0 (valid0),
        .o_valid1 (valid1),
        .o_victim (victim)
    );

    // Way 0 arrays
    icache_way_ram #(.payload_t(icache_pkg::tag_t)) tag_ram0 (
        .clk (clk), .i_we (we0), .i_index (ram_index), .i_wdata (tag_wdata), .o_rdata (tag0)
    );
    icache_way_ram #(.payload_t(icache_pkg::word_t)) data_ram0 (
        .clk (clk), .i_we (we0), .i_index (ram_index), .i_wdata (data_wdata), .o_rdata (word0)
    );

    // Way 1 arrays
    icache_way_ram #(.payload_t(icache_pkg::tag_t)) tag_ram1 (
        .clk (clk), .i_we (we1), .i_index (ram_index), .i_wdata (tag_wdata), .o_rdata (tag1)
    );
    icache_way_ram #(.payload_t(icache_pkg::word_t)) data_ram1 (
        .clk (clk), .i_we (we1), .i_index (ram_index), .i_wdata (data_wdata), .o_rdata (word1)
    );

endmodule

//--- bench/icache_properties.sv
// **************************************************
// Concurrent checks on the cache ports, bound to the top
// **************************************************

`timescale 1ns/1ps

module icache_properties (
    input logic              clk,
    input logic              rst,
    input logic              i_req,
    input logic              i_busy,
    input logic              i_valid,
    input logic              i_mem_req,
    input icache_pkg::addr_t i_mem_addr,
    input logic              i_mem_ack
);

    logic accept;

    assign accept = i_req && !i_busy;

    no_valid_in_refill: assert property (@(posedge clk) disable iff (!rst)
        !(i_valid && i_mem_req))
        else $error("o_valid high while o_mem_req is pending");

    // Refill request and address held until the ack edge
    refill_held: assert property (@(posedge clk) disable iff (!rst)
        i_mem_req && !i_mem_ack |=> i_mem_req && (i_mem_addr == $past(i_mem_addr)))
        else $error("o_mem_req or o_mem_addr changed before i_mem_ack");

    valid_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        i_valid |=> !i_valid)
        else $error("o_valid longer than one cycle");

    no_early_valid: assert property (@(posedge clk) disable iff (!rst)
        $past(accept, 2) |-> !i_valid)
        else $error("o_valid earlier than two edges after acceptance");

    hit_latency: assert property (@(posedge clk) disable iff (!rst)
        $past(accept, 3) && !i_mem_req |-> i_valid)
        else $error("hit not answered two edges after acceptance");

    // Busy from the cycle after acceptance through the response cycle
    busy_window: assert property (@(posedge clk) disable iff (!rst)
        accept || (i_busy && !i_valid) |=> i_busy)
        else $error("o_busy low before o_valid of an accepted request");

    valid_busy: assert property (@(posedge clk) disable iff (!rst)
        i_valid |-> i_busy)
        else $error("o_busy low in the o_valid cycle");

    busy_idle: assert property (@(posedge clk) disable iff (!rst)
        (!i_busy && !accept) || i_valid |=> !i_busy)
        else $error("o_busy high with no request outstanding");

endmodule

//--- bench/icache_tb.sv
// **************************************************
// Testbench for the instruction cache: fetch requests,
// refill memory model, reference model and checks
// **************************************************

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_tb;

    localparam logic [31:0] SEED          = 32'h6d69;
    localparam int          DIRECTED_REQS = 10;
    localparam int          RANDOM_REQS   = 300;
    localparam int          WATCH_CYCLES  = (DIRECTED_REQS + RANDOM_REQS) * 40 + 200;

    logic              clk = 1'b0;
    logic              rst;
    logic              i_req;
    icache_pkg::addr_t i_addr;
    logic              o_busy;
    logic              o_valid;
    icache_pkg::word_t o_data;
    logic              o_mem_req;
    icache_pkg::addr_t o_mem_addr;
    logic              i_mem_ack;
    icache_pkg::word_t i_mem_data;

    // Reference model state, per way and set
    logic              mdl_valid [2][`ICACHE_SETS];
    icache_pkg::tag_t  mdl_tag   [2][`ICACHE_SETS];
    icache_pkg::age_t  mdl_age   [2][`ICACHE_SETS];

    icache_pkg::word_t exp_word_q [$];
    logic              exp_hit_q  [$];
    icache_pkg::addr_t exp_addr_q [$];
    int                issued = 0;
    int                served = 0;
    logic              refill_seen = 1'b0;
    icache_pkg::addr_t refill_addr;
    icache_pkg::addr_t exp_addr;
    logic [31:0]       rnd_seed = SEED;
    logic [31:0]       dly_seed = SEED;
    int                delay;

    icache_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .i_req      (i_req),
        .i_addr     (i_addr),
        .o_busy     (o_busy),
        .o_valid    (o_valid),
        .o_data     (o_data),
        .o_mem_req  (o_mem_req),
        .o_mem_addr (o_mem_addr),
        .i_mem_ack  (i_mem_ack),
        .i_mem_data (i_mem_data)
    );

    bind icache_top icache_properties props_i (
        .clk        (clk),
        .rst        (rst),
        .i_req      (i_req),
        .i_busy     (o_busy),
        .i_valid    (o_valid),
        .i_mem_req  (o_mem_req),
        .i_mem_addr (o_mem_addr),
        .i_mem_ack  (i_mem_ack)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Backing memory contents, rotated left by the low index bits
    function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t addr);
        icache_pkg::word_t base;
        int unsigned       rot;
        base = addr ^ 32'hA5A5_0000;
        rot  = {27'd0, addr[6:2]};
        return (base << rot) | (base >> (32 - rot));
    endfunction

    function automatic icache_pkg::addr_t addr_of(input icache_pkg::tag_t t,
                                                  input icache_pkg::index_t i);
        return {t, i, 2'b00};
    endfunction

    function automatic void model_clear();
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                mdl_valid[w][s] = 1'b0;
                mdl_age[w][s]   = '0;
            end
        end
    endfunction

    // Expected word and hit flag, updates the model like one access
    function automatic icache_pkg::word_t cache_model(input icache_pkg::addr_t addr,
                                                      output logic hit);
        icache_pkg::index_t s;
        icache_pkg::tag_t   t;
        int                 hw;
        int                 v;
        s   = addr[`ICACHE_INDEX_W+1:2];
        t   = addr[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W+2];
        hit = 1'b0;
        hw  = 0;
        for (int w = 0; w < 2; w++) begin
            if (mdl_age[w][s] != icache_pkg::age_t'(`ICACHE_AGE_MAX)) begin
                mdl_age[w][s] = mdl_age[w][s] + 1'b1;
            end
            if (mdl_valid[w][s] && mdl_tag[w][s] == t) begin
                hit = 1'b1;
                hw  = w;
            end
        end
        if (hit) begin
            mdl_age[hw][s] = '0;
        end else begin
            if (!mdl_valid[0][s]) begin
                v = 0;
            end else if (!mdl_valid[1][s]) begin
                v = 1;
            end else if (mdl_age[1][s] > mdl_age[0][s]) begin
                v = 1;
            end else begin
                v = 0;
            end
            mdl_valid[v][s] = 1'b1;
            mdl_tag[v][s]   = t;
            mdl_age[v][s]   = '0;
        end
        return mem_word(addr);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input icache_pkg::word_t got, input icache_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: data %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_hit(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: hit flag %b, expected %b", $time, got, exp));
        end
    endtask

    task automatic check_addr(input icache_pkg::addr_t got, input icache_pkg::addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: refill address %h, expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic apply_reset();
        rst = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b1;
        model_clear();
    endtask

    // One fetch, then wait for its response
    task automatic run_access(input icache_pkg::addr_t addr);
        icache_pkg::word_t w;
        logic              h;
        while (o_busy) begin
            @(negedge clk);
        end
        w = cache_model(addr, h);
        exp_word_q.push_back(w);
        exp_hit_q.push_back(h);
        exp_addr_q.push_back(addr);
        issued = issued + 1;
        i_req  = 1'b1;
        i_addr = addr;
        @(negedge clk);
        i_req = 1'b0;
        wait (served == issued);
        @(negedge clk);
    endtask

    // **************************************************
    // Refill memory model
    // **************************************************

    always begin
        @(negedge clk);
        if (o_mem_req) begin
            dly_seed = lcg_next(dly_seed);
            delay    = int'(dly_seed[31:16] % 6);
            repeat (delay) @(negedge clk);
            i_mem_data = mem_word(o_mem_addr);
            i_mem_ack  = 1'b1;
            @(negedge clk);
            i_mem_ack  = 1'b0;
        end
    end

    // **************************************************
    // Response compare
    // **************************************************

    always @(negedge clk) begin
        if (o_mem_req && !refill_seen) begin
            refill_seen = 1'b1;
            refill_addr = o_mem_addr;
        end
        if (o_valid) begin
            if (exp_word_q.size() == 0) begin
                abort_run("The cache answered with no request outstanding");
            end else begin
                exp_addr = exp_addr_q.pop_front();
                check_word(o_data, exp_word_q.pop_front());
                check_hit(!refill_seen, exp_hit_q.pop_front());
                if (refill_seen) begin
                    check_addr(refill_addr, exp_addr);
                end
                refill_seen = 1'b0;
                served      = served + 1;
            end
        end
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("Timeout: no end of run within %0d cycles", WATCH_CYCLES);
        abort_run("The cache stopped answering requests");
    end

    initial begin
        icache_pkg::index_t idx;
        icache_pkg::tag_t   tg;
        rst        = 1'b0;
        i_req      = 1'b0;
        i_addr     = '0;
        i_mem_ack  = 1'b0;
        i_mem_data = '0;
        apply_reset();

        // Cold miss, then a hit on the same address
        run_access(addr_of(24'h000010, 6'd5));
        run_access(addr_of(24'h000010, 6'd5));
        // Second tag in set 5 fills the other way
        run_access(addr_of(24'h000020, 6'd5));
        run_access(addr_of(24'h000010, 6'd5));
        run_access(addr_of(24'h000020, 6'd5));
        // Third tag evicts the older way
        run_access(addr_of(24'h000030, 6'd5));
        run_access(addr_of(24'h000020, 6'd5));
        run_access(addr_of(24'h000010, 6'd5));

        // Random traffic over three sets and five tags
        for (int n = 0; n < RANDOM_REQS; n++) begin
            rnd_seed = lcg_next(rnd_seed);
            idx      = icache_pkg::index_t'(rnd_seed[31:16] % 3);
            rnd_seed = lcg_next(rnd_seed);
            tg       = icache_pkg::tag_t'(rnd_seed[31:16] % 5) + 24'h000100;
            run_access(addr_of(tg, idx));
        end

        // Reset in the middle of the run empties the cache
        apply_reset();
        if (o_busy || o_valid || o_mem_req) begin
            abort_run("Cache outputs not idle after reset");
        end
        run_access(addr_of(24'h000020, 6'd5));
        run_access(addr_of(24'h000020, 6'd5));

        if (served != issued || exp_word_q.size() != 0) begin
            abort_run("Some requests never got a response");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- icache.f
+incdir+include
hdl/icache_pkg.sv
hdl/icache_way_ram.sv
hdl/icache_set_state.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
bench/icache_properties.sv
bench/icache_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f icache.f --top-module icache_tb -o icache_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/icache_sim > sim.log 2>&1

grep -q "Something failed" sim.log \
    && { echo "Simulation failed, see sim.log"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
